/* common/rv_pkg.sv */
package rv_pkg;

	localparam int xlen = 32;

	typedef logic [4:0] reg_addr_t;
	typedef logic [xlen-1:0] word_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt
	} alu_op_t;

	// major opcodes of the supported subset
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jal    = 7'b1101111;

	// one instruction word, two field layouts
	// s, b and j immediates are pieced together from the r layout
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			reg_addr_t  rs2;
			reg_addr_t  rs1;
			logic [2:0] funct3;
			reg_addr_t  rd;
			logic [6:0] opcode;
		} r_view;
		struct packed {
			logic [11:0] imm;
			reg_addr_t   rs1;
			logic [2:0]  funct3;
			reg_addr_t   rd;
			logic [6:0]  opcode;
		} i_view;
	} rv_instr_t;

	// addi x0,x0,0
	localparam rv_instr_t nop_instr = 32'h0000_0013;

endpackage

/* common/pipeline_if.sv */
`timescale 1ns/1ps

interface forward_if;
	import rv_pkg::*;

	reg_addr_t mem_rd;
	logic      mem_regwrite;
	word_t     mem_result;
	reg_addr_t wb_rd;
	logic      wb_regwrite;
	word_t     wb_data;

	modport memory (output mem_rd, mem_regwrite, mem_result, wb_rd, wb_regwrite, wb_data);
	modport execute (input mem_rd, mem_regwrite, mem_result, wb_rd, wb_regwrite, wb_data);
	modport regfile (input wb_rd, wb_regwrite, wb_data);
endinterface

interface hazard_if;
	import rv_pkg::*;

	reg_addr_t id_rs1;
	reg_addr_t id_rs2;
	logic      ex_load;
	reg_addr_t ex_rd;
	logic      redirect;
	word_t     redirect_pc;
	logic      mem_busy;
	logic      stall_front;
	logic      bubble_ex;
	logic      flush_front;
	logic      stall_all;

	modport fetch (input redirect, redirect_pc, stall_front, flush_front, stall_all);
	modport decode (output id_rs1, id_rs2, input bubble_ex, flush_front, stall_all);
	modport execute (output ex_load, ex_rd, redirect, redirect_pc, input stall_all);
	modport memory (output mem_busy, input stall_all);
	modport control (input id_rs1, id_rs2, ex_load, ex_rd, redirect, mem_busy,
		output stall_front, bubble_ex, flush_front, stall_all);
endinterface

/* fetch/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
	parameter rv_pkg::word_t reset_pc = '0
) (
	input  logic              clock,
	input  logic              reset,
	input  rv_pkg::word_t     imem_data,
	output rv_pkg::word_t     imem_addr,
	hazard_if.fetch           hz,
	output rv_pkg::rv_instr_t if_instr,
	output rv_pkg::word_t     if_pc
);
	import rv_pkg::*;

	word_t     pc;
	rv_instr_t fetched;

	assign imem_addr = pc;
	assign fetched   = imem_data;

	// memory wait beats redirect, redirect beats the load-use hold
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= reset_pc;
		end else if (!hz.stall_all) begin
			if (hz.redirect) begin
				pc <= hz.redirect_pc;
			end else if (!hz.stall_front) begin
				pc <= pc + 32'd4;
			end
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			if_instr <= nop_instr;
		end else if (!hz.stall_all) begin
			if (hz.flush_front) begin
				if_instr <= nop_instr;
			end else if (!hz.stall_front) begin
				if_instr <= fetched;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!hz.stall_all && !hz.stall_front) begin
			if_pc <= pc;
		end
	end
endmodule

/* decode/register_file.sv */
`timescale 1ns/1ps

module register_file (
	input  logic              clock,
	input  logic              reset,
	input  rv_pkg::reg_addr_t rs1,
	input  rv_pkg::reg_addr_t rs2,
	forward_if.regfile        fw,
	output rv_pkg::word_t     rs1_val,
	output rv_pkg::word_t     rs2_val
);
	import rv_pkg::*;

	// x0 is not stored
	word_t regs [1:31];

	// writeback of this cycle is visible to decode at once
	function automatic word_t read_port(input reg_addr_t addr);
		if (addr == '0) begin
			return '0;
		end
		if (fw.wb_regwrite && fw.wb_rd == addr) begin
			return fw.wb_data;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rs1_val = read_port(rs1);
		rs2_val = read_port(rs2);
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (fw.wb_regwrite && fw.wb_rd != '0) begin
			regs[fw.wb_rd] <= fw.wb_data;
		end
	end
endmodule

/* decode/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit (
	input  logic              clock,
	input  logic              reset,
	input  rv_pkg::rv_instr_t if_instr,
	input  rv_pkg::word_t     if_pc,
	forward_if.regfile        fw,
	hazard_if.decode          hz,
	output rv_pkg::word_t     ex_pc,
	output rv_pkg::word_t     ex_rs1_val,
	output rv_pkg::word_t     ex_rs2_val,
	output rv_pkg::word_t     ex_imm,
	output rv_pkg::reg_addr_t ex_rs1,
	output rv_pkg::reg_addr_t ex_rs2,
	output rv_pkg::reg_addr_t ex_rd,
	output rv_pkg::alu_op_t   ex_alu_op,
	output logic              ex_alu_imm,
	output logic              ex_load,
	output logic              ex_store,
	output logic              ex_branch,
	output logic              ex_jump,
	output logic              ex_regwrite
);
	import rv_pkg::*;

	rv_instr_t  instr;
	logic [6:0] opcode;
	word_t      rs1_val;
	word_t      rs2_val;
	word_t      imm;
	alu_op_t    alu_op;
	logic       alu_imm;
	logic       load;
	logic       store;
	logic       branch;
	logic       jump;
	logic       regwrite;
	logic       uses_rs1;
	logic       uses_rs2;

	register_file register_file_i (
		.clock   (clock),
		.reset   (reset),
		.rs1     (if_instr.r_view.rs1),
		.rs2     (if_instr.r_view.rs2),
		.fw      (fw),
		.rs1_val (rs1_val),
		.rs2_val (rs2_val)
	);

	// source registers actually read, x0 where the field holds immediate bits
	assign uses_rs1 = (if_instr.r_view.opcode != opc_jal);
	assign uses_rs2 = (if_instr.r_view.opcode == opc_op) ||
		(if_instr.r_view.opcode == opc_store) || (if_instr.r_view.opcode == opc_branch);
	assign hz.id_rs1 = uses_rs1 ? if_instr.r_view.rs1 : '0;
	assign hz.id_rs2 = uses_rs2 ? if_instr.r_view.rs2 : '0;

	// a bubble is decoded as the nop
	assign instr  = (hz.bubble_ex || hz.flush_front) ? nop_instr : if_instr;
	assign opcode = instr.i_view.opcode;

	always_comb begin
		alu_op   = alu_add;
		alu_imm  = 1'b0;
		load     = 1'b0;
		store    = 1'b0;
		branch   = 1'b0;
		jump     = 1'b0;
		regwrite = 1'b0;
		imm      = {{20{instr.i_view.imm[11]}}, instr.i_view.imm};
		case (opcode)
			opc_op: begin
				regwrite = 1'b1;
				case (instr.r_view.funct3)
					3'b000: alu_op = instr.r_view.funct7[5] ? alu_sub : alu_add;
					3'b010: alu_op = alu_slt;
					3'b100: alu_op = alu_xor;
					3'b110: alu_op = alu_or;
					3'b111: alu_op = alu_and;
					default: alu_op = alu_add;
				endcase
			end
			opc_op_imm: begin
				alu_imm  = 1'b1;
				regwrite = 1'b1;
			end
			opc_load: begin
				alu_imm  = 1'b1;
				load     = 1'b1;
				regwrite = 1'b1;
			end
			opc_store: begin
				alu_imm = 1'b1;
				store   = 1'b1;
				imm     = {{20{instr.r_view.funct7[6]}}, instr.r_view.funct7, instr.r_view.rd};
			end
			opc_branch: begin
				// beq only
				branch = (instr.r_view.funct3 == 3'b000);
				imm    = {{20{instr.r_view.funct7[6]}}, instr.r_view.rd[0],
					instr.r_view.funct7[5:0], instr.r_view.rd[4:1], 1'b0};
			end
			opc_jal: begin
				jump     = 1'b1;
				regwrite = 1'b1;
				imm      = {{12{instr.r_view.funct7[6]}}, instr.r_view.rs1, instr.r_view.funct3,
					instr.r_view.rs2[0], instr.r_view.funct7[5:0], instr.r_view.rs2[4:1], 1'b0};
			end
			default: begin
				regwrite = 1'b0;
			end
		endcase
		if (instr.r_view.rd == '0) begin
			regwrite = 1'b0;
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ex_alu_imm  <= 1'b0;
			ex_load     <= 1'b0;
			ex_store    <= 1'b0;
			ex_branch   <= 1'b0;
			ex_jump     <= 1'b0;
			ex_regwrite <= 1'b0;
		end else if (!hz.stall_all) begin
			ex_alu_imm  <= alu_imm;
			ex_load     <= load;
			ex_store    <= store;
			ex_branch   <= branch;
			ex_jump     <= jump;
			ex_regwrite <= regwrite;
		end
	end

	always_ff @(posedge clock) begin
		if (!hz.stall_all) begin
			ex_pc      <= if_pc;
			ex_rs1_val <= rs1_val;
			ex_rs2_val <= rs2_val;
			ex_imm     <= imm;
			ex_rs1     <= hz.id_rs1;
			ex_rs2     <= hz.id_rs2;
			ex_rd      <= instr.r_view.rd;
			ex_alu_op  <= alu_op;
		end
	end
endmodule

/* execute/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
	input  logic              clock,
	input  logic              reset,
	input  rv_pkg::word_t     ex_pc,
	input  rv_pkg::word_t     ex_rs1_val,
	input  rv_pkg::word_t     ex_rs2_val,
	input  rv_pkg::word_t     ex_imm,
	input  rv_pkg::reg_addr_t ex_rs1,
	input  rv_pkg::reg_addr_t ex_rs2,
	input  rv_pkg::reg_addr_t ex_rd,
	input  rv_pkg::alu_op_t   ex_alu_op,
	input  logic              ex_alu_imm,
	input  logic              ex_load,
	input  logic              ex_store,
	input  logic              ex_branch,
	input  logic              ex_jump,
	input  logic              ex_regwrite,
	forward_if.execute        fw,
	hazard_if.execute         hz,
	output rv_pkg::word_t     mem_alu_out,
	output rv_pkg::word_t     mem_store_data,
	output rv_pkg::reg_addr_t mem_rd,
	output logic              mem_load,
	output logic              mem_store,
	output logic              mem_regwrite
);
	import rv_pkg::*;

	word_t op_a;
	word_t rs2_fwd;
	word_t op_b;
	word_t alu_out;
	word_t result;
	logic  taken;

	// the memory stage holds the younger result, so it is checked first
	function automatic word_t forward_operand(input reg_addr_t rs, input word_t reg_val);
		if (rs != '0 && fw.mem_regwrite && fw.mem_rd == rs) begin
			return fw.mem_result;
		end
		if (rs != '0 && fw.wb_regwrite && fw.wb_rd == rs) begin
			return fw.wb_data;
		end
		return reg_val;
	endfunction

	always_comb begin
		op_a    = forward_operand(ex_rs1, ex_rs1_val);
		rs2_fwd = forward_operand(ex_rs2, ex_rs2_val);
	end

	assign op_b = ex_alu_imm ? ex_imm : rs2_fwd;

	always_comb begin
		case (ex_alu_op)
			alu_sub: alu_out = op_a - op_b;
			alu_and: alu_out = op_a & op_b;
			alu_or:  alu_out = op_a | op_b;
			alu_xor: alu_out = op_a ^ op_b;
			alu_slt: alu_out = word_t'($signed(op_a) < $signed(op_b));
			default: alu_out = op_a + op_b;
		endcase
	end

	// jal links the return address
	assign result = ex_jump ? ex_pc + 32'd4 : alu_out;
	assign taken  = ex_branch && (op_a == rs2_fwd);

	assign hz.redirect    = taken || ex_jump;
	assign hz.redirect_pc = ex_pc + ex_imm;
	assign hz.ex_load     = ex_load;
	assign hz.ex_rd       = ex_rd;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			mem_load     <= 1'b0;
			mem_store    <= 1'b0;
			mem_regwrite <= 1'b0;
		end else if (!hz.stall_all) begin
			mem_load     <= ex_load;
			mem_store    <= ex_store;
			mem_regwrite <= ex_regwrite;
		end
	end

	always_ff @(posedge clock) begin
		if (!hz.stall_all) begin
			mem_alu_out    <= result;
			mem_store_data <= rs2_fwd;
			mem_rd         <= ex_rd;
		end
	end

	// the slot after a redirect is the flushed bubble
	assert property (@(posedge clock) disable iff (!reset)
		hz.redirect && !hz.stall_all |=> !hz.redirect);
endmodule

/* source/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
	input  logic              clock,
	input  logic              reset,
	input  rv_pkg::word_t     mem_alu_out,
	input  rv_pkg::word_t     mem_store_data,
	input  rv_pkg::reg_addr_t mem_rd,
	input  logic              mem_load,
	input  logic              mem_store,
	input  logic              mem_regwrite,
	output logic              wb_cyc,
	output logic              wb_stb,
	output logic              wb_we,
	output rv_pkg::word_t     wb_adr,
	output rv_pkg::word_t     wb_dat_w,
	input  rv_pkg::word_t     wb_dat_r,
	input  logic              wb_ack,
	forward_if.memory         fw,
	hazard_if.memory          hz
);
	import rv_pkg::*;

	logic  access;
	logic  ack_q;
	logic  wb_load_q;
	word_t wb_alu_q;
	word_t wb_mem_q;

	assign access = mem_load || mem_store;

	// cyc and stb drop for one cycle after every ack
	assign wb_cyc   = access && !ack_q;
	assign wb_stb   = wb_cyc;
	assign wb_we    = mem_store && wb_cyc;
	assign wb_adr   = mem_alu_out;
	assign wb_dat_w = mem_store_data;

	assign hz.mem_busy = access && !(wb_stb && wb_ack);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= wb_stb && wb_ack;
		end
	end

	assign fw.mem_rd       = mem_rd;
	assign fw.mem_regwrite = mem_regwrite;
	assign fw.mem_result   = mem_alu_out;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			fw.wb_regwrite <= 1'b0;
			wb_load_q      <= 1'b0;
		end else if (!hz.stall_all) begin
			fw.wb_regwrite <= mem_regwrite;
			wb_load_q      <= mem_load;
		end
	end

	always_ff @(posedge clock) begin
		if (!hz.stall_all) begin
			fw.wb_rd <= mem_rd;
			wb_alu_q <= mem_alu_out;
			wb_mem_q <= wb_dat_r;
		end
	end

	// writeback select
	assign fw.wb_data = wb_load_q ? wb_mem_q : wb_alu_q;

	// request held unchanged until the slave answers
	assert property (@(posedge clock) disable iff (!reset)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w));
endmodule

/* source/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
	input logic       clock,
	input logic       reset,
	hazard_if.control hz
);
	logic load_use;
	logic flush_q;

	assign load_use = hz.ex_load && hz.ex_rd != '0 &&
		(hz.ex_rd == hz.id_rs1 || hz.ex_rd == hz.id_rs2);

	assign hz.stall_all   = hz.mem_busy;
	assign hz.flush_front = hz.redirect;
	assign hz.stall_front = load_use && !hz.redirect;
	// the record keeps the slot of the second younger instruction empty
	assign hz.bubble_ex   = hz.stall_front || flush_q;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			flush_q <= 1'b0;
		end else if (!hz.stall_all) begin
			flush_q <= hz.flush_front;
		end
	end

	// a load never redirects, so both cannot come from the EX slot
	assert property (@(posedge clock) disable iff (!reset) !(load_use && hz.redirect));
endmodule

/* source/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
	parameter rv_pkg::word_t reset_pc = '0
) (
	input  logic          clock,
	input  logic          reset,
	output rv_pkg::word_t imem_addr,
	input  rv_pkg::word_t imem_data,
	output logic          wb_cyc,
	output logic          wb_stb,
	output logic          wb_we,
	output rv_pkg::word_t wb_adr,
	output rv_pkg::word_t wb_dat_w,
	input  rv_pkg::word_t wb_dat_r,
	input  logic          wb_ack
);
	import rv_pkg::*;

	rv_instr_t if_instr;
	word_t     if_pc;
	word_t     ex_pc;
	word_t     ex_rs1_val;
	word_t     ex_rs2_val;
	word_t     ex_imm;
	reg_addr_t ex_rs1;
	reg_addr_t ex_rs2;
	reg_addr_t ex_rd;
	alu_op_t   ex_alu_op;
	logic      ex_alu_imm;
	logic      ex_load;
	logic      ex_store;
	logic      ex_branch;
	logic      ex_jump;
	logic      ex_regwrite;
	word_t     mem_alu_out;
	word_t     mem_store_data;
	reg_addr_t mem_rd;
	logic      mem_load;
	logic      mem_store;
	logic      mem_regwrite;

	forward_if fw ();
	hazard_if  hz ();

	fetch_unit #(
		.reset_pc (reset_pc)
	) fetch_unit_i (
		.clock, .reset, .imem_data, .imem_addr, .hz (hz.fetch), .if_instr, .if_pc
	);

	decode_unit decode_unit_i (
		.clock, .reset, .if_instr, .if_pc, .fw (fw.regfile), .hz (hz.decode),
		.ex_pc, .ex_rs1_val, .ex_rs2_val, .ex_imm, .ex_rs1, .ex_rs2, .ex_rd, .ex_alu_op,
		.ex_alu_imm, .ex_load, .ex_store, .ex_branch, .ex_jump, .ex_regwrite
	);

	execute_unit execute_unit_i (
		.clock, .reset, .ex_pc, .ex_rs1_val, .ex_rs2_val, .ex_imm, .ex_rs1, .ex_rs2, .ex_rd,
		.ex_alu_op, .ex_alu_imm, .ex_load, .ex_store, .ex_branch, .ex_jump, .ex_regwrite,
		.fw (fw.execute), .hz (hz.execute),
		.mem_alu_out, .mem_store_data, .mem_rd, .mem_load, .mem_store, .mem_regwrite
	);

	memory_stage memory_stage_i (
		.clock, .reset, .mem_alu_out, .mem_store_data, .mem_rd, .mem_load, .mem_store,
		.mem_regwrite, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.fw (fw.memory), .hz (hz.memory)
	);

	hazard_unit hazard_unit_i (
		.clock, .reset, .hz (hz.control)
	);
endmodule

/* tb/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int prog_len = 32;
localparam int store_count = 13;
// only the flushed paths store here
localparam logic [31:0] poison_addr = 32'h0000_03fc;

logic [31:0] rom [0:prog_len-1];
// {address, data} of each store, in program order
logic [63:0] exp_store [0:store_count-1];

function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opcode);
	return {imm, rs1, f3, rd, opcode};
endfunction

// sw src, imm(base)
function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] src,
	input logic [4:0] base);
	return {imm[11:5], src, base, 3'b010, imm[4:0], 7'b0100011};
endfunction

// beq rs1, rs2, offset
function automatic logic [31:0] b_format(input logic [12:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1);
	return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] j_format(input logic [20:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

task automatic load_program();
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] link;
	a = 32'd100;
	b = -7;
	// jal sits at word 28
	link = reset_pc + 32'd116;
	rom[0] = i_format(12'd100, 5'd0, 3'b000, 5'd1, 7'b0010011);
	rom[1] = i_format(-12'sd7, 5'd0, 3'b000, 5'd2, 7'b0010011);
	// each alu operation on x1 and x2 has its result stored
	rom[2] = r_format(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
	rom[3] = s_format(12'h200, 5'd3, 5'd0);
	rom[4] = r_format(7'h20, 5'd2, 5'd1, 3'b000, 5'd4);
	rom[5] = s_format(12'h204, 5'd4, 5'd0);
	rom[6] = r_format(7'h00, 5'd2, 5'd1, 3'b111, 5'd5);
	rom[7] = s_format(12'h208, 5'd5, 5'd0);
	rom[8] = r_format(7'h00, 5'd2, 5'd1, 3'b110, 5'd6);
	rom[9] = s_format(12'h20c, 5'd6, 5'd0);
	rom[10] = r_format(7'h00, 5'd2, 5'd1, 3'b100, 5'd7);
	rom[11] = s_format(12'h210, 5'd7, 5'd0);
	rom[12] = r_format(7'h00, 5'd1, 5'd2, 3'b010, 5'd8);
	rom[13] = s_format(12'h214, 5'd8, 5'd0);
	rom[14] = r_format(7'h00, 5'd2, 5'd1, 3'b010, 5'd9);
	rom[15] = s_format(12'h218, 5'd9, 5'd0);
	rom[16] = i_format(12'd7, 5'd3, 3'b000, 5'd10, 7'b0010011);
	rom[17] = s_format(12'h21c, 5'd10, 5'd0);
	// load-use pairs where the second feeds the store data
	rom[18] = i_format(12'h204, 5'd0, 3'b010, 5'd11, 7'b0000011);
	rom[19] = r_format(7'h00, 5'd1, 5'd11, 3'b000, 5'd12);
	rom[20] = s_format(12'h220, 5'd12, 5'd0);
	rom[21] = i_format(12'h200, 5'd0, 3'b010, 5'd13, 7'b0000011);
	rom[22] = s_format(12'h224, 5'd13, 5'd0);
	// untaken beq, taken beq, jal
	rom[23] = b_format(13'd8, 5'd2, 5'd1);
	rom[24] = s_format(12'h228, 5'd1, 5'd0);
	rom[25] = b_format(13'd8, 5'd3, 5'd3);
	rom[26] = s_format(poison_addr[11:0], 5'd1, 5'd0);
	rom[27] = s_format(12'h22c, 5'd2, 5'd0);
	rom[28] = j_format(21'd8, 5'd14);
	rom[29] = s_format(poison_addr[11:0], 5'd1, 5'd0);
	rom[30] = s_format(12'h230, 5'd14, 5'd0);
	// spin here
	rom[31] = j_format(21'd0, 5'd0);
	exp_store[0] = {32'h0000_0200, a + b};
	exp_store[1] = {32'h0000_0204, a - b};
	exp_store[2] = {32'h0000_0208, a & b};
	exp_store[3] = {32'h0000_020c, a | b};
	exp_store[4] = {32'h0000_0210, a ^ b};
	exp_store[5] = {32'h0000_0214, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0};
	exp_store[6] = {32'h0000_0218, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0};
	exp_store[7] = {32'h0000_021c, a + b + 32'd7};
	exp_store[8] = {32'h0000_0220, a - b + a};
	exp_store[9] = {32'h0000_0224, a + b};
	exp_store[10] = {32'h0000_0228, a};
	exp_store[11] = {32'h0000_022c, b};
	exp_store[12] = {32'h0000_0230, link};
endtask

`endif

/* tb/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

	localparam logic [31:0] reset_pc = 32'h0000_0100;
	localparam int max_cycles = 2000;

	logic        clock;
	logic        reset;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;

	logic [31:0] dmem [0:255];
	logic [31:0] rom_index;
	int          store_idx;
	int          wait_cycles;
	int          mismatch_count;
	int          error_count;
	integer      seed;

	`include "tb_program.svh"

	cpu_top #(
		.reset_pc (reset_pc)
	) cpu_top_i (
		.clock, .reset, .imem_addr, .imem_data, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
		.wb_dat_w, .wb_dat_r, .wb_ack
	);

	task automatic note_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		mismatch_count++;
		$display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
	endtask

	task automatic raise_error(input string what);
		error_count++;
		$display("Error at %0t: %s", $time, what);
	endtask

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// combinational instruction ROM, nop outside the program
	assign rom_index = (imem_addr - reset_pc) >> 2;
	assign imem_data = (rom_index < prog_len) ? rom[rom_index] : 32'h0000_0013;

	// data memory slave, 0 to 3 wait cycles before each ack
	always @(posedge clock) begin
		if (!reset) begin
			wb_ack <= 1'b0;
			wait_cycles <= 0;
			store_idx <= 0;
		end else if (wb_ack) begin
			wb_ack <= 1'b0;
			if (wb_we) begin
				store_idx <= store_idx + 1;
			end
		end else if (wb_stb) begin
			if (wait_cycles == 0) begin
				wb_ack <= 1'b1;
				if (wb_we) begin
					dmem[wb_adr[9:2]] <= wb_dat_w;
				end else begin
					wb_dat_r <= dmem[wb_adr[9:2]];
				end
				wait_cycles <= $unsigned($random(seed)) % 4;
			end else begin
				wait_cycles <= wait_cycles - 1;
			end
		end
	end

	// value checks on the falling edge, where nothing moves
	assert property (@(negedge clock) !reset |-> imem_addr == reset_pc)
		else note_mismatch("imem_addr", reset_pc, imem_addr);

	assert property (@(negedge clock) !reset |-> !wb_cyc && !wb_stb && !wb_we)
		else raise_error("bus request active during reset");

	assert property (@(negedge clock) disable iff (!reset)
		wb_stb && wb_ack && wb_we && store_idx < store_count |->
		wb_adr == exp_store[store_idx][63:32])
		else note_mismatch("wb_adr", exp_store[store_idx][63:32], wb_adr);

	assert property (@(negedge clock) disable iff (!reset)
		wb_stb && wb_ack && wb_we && store_idx < store_count |->
		wb_dat_w == exp_store[store_idx][31:0])
		else note_mismatch("wb_dat_w", exp_store[store_idx][31:0], wb_dat_w);

	assert property (@(negedge clock) disable iff (!reset)
		wb_stb && wb_ack && wb_we |-> store_idx < store_count)
		else raise_error("more stores than the program makes");

	assert property (@(negedge clock) disable iff (!reset)
		wb_stb && wb_we |-> wb_adr != poison_addr)
		else raise_error("store from a flushed path reached the bus");

	// wishbone classic handshake
	assert property (@(posedge clock) disable iff (!reset) wb_cyc == wb_stb)
		else raise_error("cyc and stb differ");

	assert property (@(posedge clock) disable iff (!reset)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) &&
		$stable(wb_dat_w))
		else raise_error("request changed or dropped before ack");

	assert property (@(posedge clock) disable iff (!reset) wb_stb && wb_ack |=> !wb_stb)
		else raise_error("stb still high in the cycle after ack");

	initial begin
		int cycles;
		seed = 88;
		mismatch_count = 0;
		error_count = 0;
		reset = 1'b0;
		wb_ack = 1'b0;
		wb_dat_r = '0;
		store_idx = 0;
		wait_cycles = 0;
		for (int i = 0; i < 256; i++) begin
			dmem[i] = 32'hc0de_0000 ^ (i << 2);
		end
		load_program();
		repeat (5) @(posedge clock);
		reset <= 1'b1;
		cycles = 0;
		while (store_idx < store_count && cycles < max_cycles) begin
			@(posedge clock);
			cycles++;
		end
		if (store_idx < store_count) begin
			raise_error("timeout waiting for the expected stores");
		end
		// keep the spin loop running to catch a late stray store
		repeat (40) @(posedge clock);
		$display("stores seen: %0d of %0d, mismatches: %0d, other errors: %0d",
			store_idx, store_count, mismatch_count, error_count);
		if (mismatch_count == 0 && error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end
endmodule

/* all.f */
+incdir+tb
common/rv_pkg.sv
common/pipeline_if.sv
fetch/fetch_unit.sv
decode/register_file.sv
decode/decode_unit.sv
execute/execute_unit.sv
source/memory_stage.sv
source/hazard_unit.sv
source/cpu_top.sv
tb/cpu_tb.sv
